// ==== frontend_top.f ====
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/bus_tracker.sv
design/prefetch_queue.sv
design/instr_assembly.sv
design/frontend_top.sv
sim/frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the frontend testbench with Verilator and run it
# the exit status is nonzero when the build fails or the testbench stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module frontend_tb \
	-f frontend_top.f \
	-o frontend_sim \
	&& ./obj_dir/frontend_sim \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// ==== sim/frontend_tb.sv ====
// testbench for the instruction fetch frontend
// clock, reset and a bus responder with random address stalls and in-order data
// decoder model with random decode stalls and jumps to random halfword targets
// reference image of instruction memory with one bus error window
// checks of the address phase, the outstanding count and every valid cir halfword

`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
	localparam int          MAX_PENDING  = 2;
	localparam int          NUM_INSTR    = 1000;
	localparam int          MAX_CYCLES   = 20000;
	// words in [ERR_LO, ERR_HI) answer with a bus error
	localparam logic [31:0] ERR_LO       = 32'h0000_01c0;
	localparam logic [31:0] ERR_HI       = 32'h0000_01e0;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] jump_target;
	logic        jump_target_vld;
	wire         jump_target_rdy;
	wire  [31:0] mem_addr;
	wire         mem_addr_vld;
	logic        mem_addr_rdy;
	logic [31:0] mem_data;
	logic        mem_data_err;
	logic        mem_data_vld;
	wire  [31:0] cir;
	wire  [1:0]  cir_vld;
	wire  [1:0]  cir_err;
	logic [1:0]  cir_use;

	// stimulus side is written on the falling edge
	integer      seed;
	int          cyc;
	int          returned;
	int          jumps_asked;
	logic        delay_two;

	// monitor side is written just before the rising edge
	logic [31:0] fetch_log [$];
	int          due_log [$];
	int          last_due;
	logic [31:0] next_fetch;
	logic [31:0] pc;
	logic        held;
	logic [31:0] held_addr;
	int          instr_count;
	int          jumps_taken;
	int          odd_jumps;
	int          err_halves;

	always #4 clk = ~clk;

	frontend_top #(.RESET_VECTOR(RESET_VECTOR)) dut0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_err         (cir_err),
		.cir_use         (cir_use)
	);

	// ------------------------------------------------------------
	// reference memory image
	// ------------------------------------------------------------

	// each halfword has bits 1 and 0 equal, so about half open a 32-bit instruction
	function automatic logic [15:0] image_half(input logic [31:0] addr);
		logic [31:0] x;
		x = {addr[31:1], 1'b0} * 32'h9e37_79b9;
		x = x ^ (x >> 13);
		x = x * 32'h85eb_ca6b;
		return {x[31:18], x[17], x[17]};
	endfunction

	// the error flag belongs to the whole bus word
	function automatic logic in_err_window(input logic [31:0] addr);
		logic [31:0] waddr;
		waddr = {addr[31:2], 2'b00};
		return (waddr >= ERR_LO) && (waddr < ERR_HI);
	endfunction

	// ------------------------------------------------------------
	// error reporting
	// ------------------------------------------------------------

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, name, got, expected));
		end
	endtask

	// ------------------------------------------------------------
	// stimulus driven on the falling edge
	// ------------------------------------------------------------

	// random address stalls and the return of the oldest accepted word once its delay is over
	task automatic drive_bus();
		logic [31:0] rnd;
		logic [31:0] waddr;
		rnd          = $random(seed);
		mem_addr_rdy = (rnd[1:0] != 2'b00);
		// delay for an address the bus accepts in this cycle
		delay_two    = rnd[2];
		mem_data_vld = 1'b0;
		mem_data_err = 1'b0;
		mem_data     = $random(seed);
		if (returned < fetch_log.size() && due_log[returned] <= cyc) begin
			waddr        = fetch_log[returned];
			mem_data     = {image_half(waddr + 32'd2), image_half(waddr)};
			mem_data_err = in_err_window(waddr);
			mem_data_vld = 1'b1;
			returned     = returned + 1;
		end
	endtask

	// decode takes a whole instruction or nothing
	task automatic drive_decode();
		logic [31:0] rnd;
		logic [1:0]  len;
		rnd = $random(seed);
		len = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
		if (cir_vld == 2'd0) begin
			cir_use = 2'd0;
		end else if (rnd[1:0] == 2'b00 || cir_vld < len) begin
			cir_use = 2'd0;
		end else begin
			cir_use = len;
		end
	endtask

	// a request stays up until the frontend takes it
	task automatic drive_jump();
		logic [31:0] rnd;
		logic [31:0] offs;
		rnd  = $random(seed);
		offs = $random(seed);
		if (jump_target_vld && jumps_taken == jumps_asked) begin
			jump_target_vld = 1'b0;
		end else if (!jump_target_vld && cyc > 300 && rnd[4:0] == 5'd0) begin
			jump_target     = RESET_VECTOR + (offs & 32'h0000_03fe);
			jump_target_vld = 1'b1;
			jumps_asked     = jumps_asked + 1;
		end
	endtask

	// ------------------------------------------------------------
	// monitor sampled one ns before the rising edge
	// ------------------------------------------------------------

	task automatic check_addr_phase();
		logic [31:0] exp_addr;
		logic        jump_taken;
		int          due;
		jump_taken = jump_target_vld && jump_target_rdy;
		if (cyc == 1) begin
			check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd0);
			check_value("cir_vld", 32'(cir_vld), 32'd0);
		end
		if (cyc == 2) begin
			check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd1);
		end
		// jumps are refused only while a stalled address is repeated
		check_value("jump_target_rdy", 32'(jump_target_rdy), 32'(!held));
		// an address the bus did not take comes back unchanged
		if (held) begin
			check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd1);
			check_value("mem_addr", mem_addr, held_addr);
		end
		held      = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
		if (mem_addr_vld && mem_addr_rdy) begin
			exp_addr = jump_taken ? {jump_target[31:2], 2'b00} : next_fetch;
			check_value("mem_addr", mem_addr, exp_addr);
			next_fetch = mem_addr + 32'd4;
			// data comes back in order, one or two cycles after the transfer
			due = cyc + 1 + int'(delay_two);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			fetch_log.push_back(mem_addr);
			due_log.push_back(due);
		end else if (jump_taken) begin
			next_fetch = {jump_target[31:2], 2'b00};
		end
		if (fetch_log.size() - returned > MAX_PENDING) begin
			fail_run("more than two fetches are outstanding on the bus");
		end
	endtask

	// every valid halfword must be the image at pc onwards
	task automatic check_cir();
		logic [31:0] half_addr;
		for (int i = 0; i < 2; i++) begin
			if (i < int'(cir_vld)) begin
				half_addr = pc + 32'(2 * i);
				check_value($sformatf("cir halfword %0d", i), 32'(cir[16 * i +: 16]),
					32'(image_half(half_addr)));
				check_value($sformatf("cir_err[%0d]", i), 32'(cir_err[i]),
					32'(in_err_window(half_addr)));
			end
		end
	endtask

	task automatic follow_decode();
		logic [31:0] half_addr;
		if (cir_use != 2'd0) begin
			for (int i = 0; i < 2; i++) begin
				half_addr = pc + 32'(2 * i);
				if (i < int'(cir_use) && in_err_window(half_addr)) begin
					err_halves = err_halves + 1;
				end
			end
			pc          = pc + {29'd0, cir_use, 1'b0};
			instr_count = instr_count + 1;
		end
		// a taken jump restarts the expected stream at the target
		if (jump_target_vld && jump_target_rdy) begin
			pc          = jump_target;
			jumps_taken = jumps_taken + 1;
			odd_jumps   = odd_jumps + int'(jump_target[1]);
		end
	endtask

	always @(negedge clk) begin
		#3;
		if (!rst_n) begin
			fetch_log.delete();
			due_log.delete();
			last_due    = 0;
			next_fetch  = RESET_VECTOR;
			pc          = RESET_VECTOR;
			held        = 1'b0;
			held_addr   = 32'd0;
			instr_count = 0;
			jumps_taken = 0;
			odd_jumps   = 0;
			err_halves  = 0;
		end else begin
			check_addr_phase();
			check_cir();
			follow_decode();
		end
	end

	// ------------------------------------------------------------
	// reset and main run
	// ------------------------------------------------------------

	initial begin
		seed            = 32'h147;
		rst_n           = 1'b0;
		jump_target     = RESET_VECTOR;
		jump_target_vld = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = 32'd0;
		mem_data_err    = 1'b0;
		mem_data_vld    = 1'b0;
		cir_use         = 2'd0;
		delay_two       = 1'b0;
		cyc             = 0;
		returned        = 0;
		jumps_asked     = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// one pass per cycle until decode has taken enough instructions
		while (instr_count < NUM_INSTR && cyc < MAX_CYCLES) begin
			cyc = cyc + 1;
			drive_bus();
			drive_decode();
			drive_jump();
			@(negedge clk);
		end
		if (instr_count < NUM_INSTR) begin
			fail_run("timeout: decode did not receive enough instructions");
		end else if (jumps_taken == 0 || odd_jumps == 0 || err_halves == 0) begin
			fail_run("the run missed jumps, jumps to an upper halfword or the error window");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== design/frontend_top.sv ====
// top level of the instruction fetch frontend
// address phase control, bus tracking, prefetch queue and instruction assembly
// joined by the internal strobes between them

`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
	parameter fetch_pkg::addr_t RESET_VECTOR = '0
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire fetch_pkg::addr_t     jump_target,
	input  wire                       jump_target_vld,
	output wire                       jump_target_rdy,
	output wire fetch_pkg::addr_t     mem_addr,
	output wire                       mem_addr_vld,
	input  wire                       mem_addr_rdy,
	input  wire fetch_pkg::word_t     mem_data,
	input  wire                       mem_data_err,
	input  wire                       mem_data_vld,
	output wire fetch_pkg::word_t     cir,
	output wire fetch_pkg::level_t    cir_vld,
	output wire fetch_pkg::hw_mask_t  cir_err,
	input  wire fetch_pkg::level_t    cir_use
);

	import fetch_pkg::*;

	// ------------------------------------------------------------
	// internal strobes
	// ------------------------------------------------------------

	wire           jump_now;
	wire           fetch_issue;
	hw_mask_t      data_hw_mask;
	wire           data_live;
	wire           fetch_stall;
	wire           queue_empty;
	wire           queue_full;
	wire           queue_almost_full;
	word_t         head_data;
	wire           head_err;
	hw_mask_t      head_hw_mask;
	wire           cir_room;

	fetch_ctrl #(.RESET_VECTOR(RESET_VECTOR)) ctrl0 (.clk, .rst_n, .jump_target,
		.jump_target_vld, .jump_target_rdy, .jump_now, .mem_addr, .mem_addr_vld,
		.mem_addr_rdy, .fetch_stall, .fetch_issue, .data_hw_mask);

	// stall and liveness come from registered counts
	bus_tracker tracker0 (.clk, .rst_n, .fetch_issue, .jump_now, .mem_data_vld,
		.queue_full, .queue_almost_full, .data_live, .fetch_stall);

	prefetch_queue queue0 (.clk, .rst_n, .jump_now, .data_live, .mem_data,
		.mem_data_err, .data_hw_mask, .cir_room, .queue_empty, .queue_full,
		.queue_almost_full, .head_data, .head_err, .head_hw_mask);

	// bus data bypasses the queue whenever the queue is empty
	instr_assembly assembly0 (.clk, .rst_n, .jump_now, .data_live, .mem_data,
		.mem_data_err, .data_hw_mask, .queue_empty, .head_data, .head_err,
		.head_hw_mask, .cir_use, .cir, .cir_vld, .cir_err, .cir_room);

endmodule

`default_nettype wire

// ==== design/instr_assembly.sv ====
// instruction assembly for decode
// selects bus data or the queue head and aligns a word starting at its upper half
// three-halfword yard of cir and one spare halfword, shifted by decode use
// fill level, capped valid count and per-halfword bus error flags

`timescale 1ns/1ps
`default_nettype none

module instr_assembly (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       jump_now,
	input  wire                       data_live,
	input  wire fetch_pkg::word_t     mem_data,
	input  wire                       mem_data_err,
	input  wire fetch_pkg::hw_mask_t  data_hw_mask,
	input  wire                       queue_empty,
	input  wire fetch_pkg::word_t     head_data,
	input  wire                       head_err,
	input  wire fetch_pkg::hw_mask_t  head_hw_mask,
	input  wire fetch_pkg::level_t    cir_use,
	output fetch_pkg::word_t          cir,
	output fetch_pkg::level_t         cir_vld,
	output fetch_pkg::hw_mask_t       cir_err,
	output logic                      cir_room
);

	import fetch_pkg::*;

	localparam int HW = $bits(half_t);

	half_t           spare_q;
	logic [2:0]      err_q;
	level_t          level_q;
	word_t           fetch_data;
	hw_mask_t        fetch_mask;
	logic            fetch_err;
	logic            fetch_vld;
	word_t           fetch_aligned;
	logic [3*HW-1:0] yard_shifted;
	logic [3*HW-1:0] yard_next;
	logic [2:0]      err_shifted;
	logic [2:0]      err_next;
	level_t          level_rest;
	level_t          fill;
	level_t          level_next;

	// ------------------------------------------------------------
	// fetch source and alignment
	// ------------------------------------------------------------

	// the queue head is older than anything on the bus
	assign fetch_data = queue_empty ? mem_data : head_data;
	assign fetch_mask = queue_empty ? data_hw_mask : head_hw_mask;
	assign fetch_err  = queue_empty ? mem_data_err : head_err;
	assign fetch_vld  = !queue_empty || data_live;

	// a word with only its upper halfword valid has that halfword moved down
	assign fetch_aligned = {fetch_data[HW +: HW],
		fetch_mask[0] ? fetch_data[0 +: HW] : fetch_data[HW +: HW]};

	// what remains in the yard once decode has taken its halfwords
	assign level_rest = level_q - cir_use;

	// a full word fits below two remaining halfwords, a single halfword below three
	assign cir_room = level_rest <= ((fetch_mask == 2'b11) ? 2'd1 : 2'd2);

	// ------------------------------------------------------------
	// shift and overlay
	// ------------------------------------------------------------

	always_comb begin
		// slots beyond the remaining level are don't care, so reuse what is cheap
		if (cir_use[1]) begin
			yard_shifted = {spare_q, cir[HW +: HW], spare_q};
			err_shifted  = err_q >> 2;
		end else if (cir_use[0]) begin
			yard_shifted = {spare_q, spare_q, cir[HW +: HW]};
			err_shifted  = err_q >> 1;
		end else begin
			yard_shifted = {spare_q, cir};
			err_shifted  = err_q;
		end
		// fresh halfwords land right above the remaining ones
		if (!cir_room) begin
			yard_next = yard_shifted;
			err_next  = err_shifted;
		end else if (level_rest[1]) begin
			yard_next = {fetch_aligned[0 +: HW], yard_shifted[0 +: 2*HW]};
			err_next  = {fetch_err, err_shifted[1:0]};
		end else if (level_rest[0]) begin
			yard_next = {fetch_aligned, yard_shifted[0 +: HW]};
			err_next  = {{2{fetch_err}}, err_shifted[0]};
		end else begin
			yard_next = {yard_shifted[2*HW +: HW], fetch_aligned};
			err_next  = {err_shifted[2], {2{fetch_err}}};
		end
	end

	assign fill       = (cir_room && fetch_vld) ? ((&fetch_mask) ? 2'd2 : 2'd1) : 2'd0;
	assign level_next = jump_now ? 2'd0 : level_rest + fill;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level_q <= 2'd0;
			cir_vld <= 2'd0;
			err_q   <= 3'b000;
		end else begin
			level_q <= level_next;
			// decode sees at most the two halfwords of cir
			cir_vld <= level_next[1] ? 2'd2 : level_next;
			err_q   <= err_next;
		end
	end

	always_ff @(posedge clk) begin
		{spare_q, cir} <= yard_next;
	end

	assign cir_err = err_q[1:0];

endmodule

`default_nettype wire

// ==== design/prefetch_queue.sv ====
// prefetch queue between the bus and the instruction register
// two compact entries, each a word with its bus error and halfword mask
// push, pop and jump clear, plus queue status and head outputs

`timescale 1ns/1ps
`default_nettype none

module prefetch_queue (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       jump_now,
	input  wire                       data_live,
	input  wire fetch_pkg::word_t     mem_data,
	input  wire                       mem_data_err,
	input  wire fetch_pkg::hw_mask_t  data_hw_mask,
	input  wire                       cir_room,
	output logic                      queue_empty,
	output logic                      queue_full,
	output logic                      queue_almost_full,
	output fetch_pkg::word_t          head_data,
	output logic                      head_err,
	output fetch_pkg::hw_mask_t       head_hw_mask
);

	import fetch_pkg::*;

	word_t    data_q [2];
	logic     err_q  [2];
	hw_mask_t mask_q [2];
	logic     vld0;
	logic     vld1;
	logic     push;
	logic     pop;

	// an entry is valid when any of its halfwords is, and entries fill from 0
	assign vld0 = |mask_q[0];
	assign vld1 = |mask_q[1];

	// with room and nothing queued the word goes straight to the instruction register
	assign push = data_live && !(cir_room && !vld0);
	assign pop  = cir_room && vld0;

	assign queue_empty       = !vld0;
	assign queue_almost_full = vld0;
	assign queue_full        = vld1;
	assign head_data         = data_q[0];
	assign head_err          = err_q[0];
	assign head_hw_mask      = mask_q[0];

	// ------------------------------------------------------------
	// entry validity
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mask_q[0] <= 2'b00;
			mask_q[1] <= 2'b00;
		end else if (jump_now) begin
			mask_q[0] <= 2'b00;
			mask_q[1] <= 2'b00;
		end else begin
			// entry 0 takes entry 1 on a pop, or the new word when it would be empty
			if (pop) begin
				mask_q[0] <= vld1 ? mask_q[1] : (push ? data_hw_mask : 2'b00);
			end else if (!vld0 && push) begin
				mask_q[0] <= data_hw_mask;
			end
			// entry 1 only ever holds a word pushed behind a valid entry 0
			if (pop) begin
				mask_q[1] <= (vld1 && push) ? data_hw_mask : 2'b00;
			end else if (!vld1 && vld0 && push) begin
				mask_q[1] <= data_hw_mask;
			end
		end
	end

	// payload follows the validity moves above
	always_ff @(posedge clk) begin
		if (pop || (push && !vld0)) begin
			data_q[0] <= vld1 ? data_q[1] : mem_data;
			err_q[0]  <= vld1 ? err_q[1] : mem_data_err;
		end
		if (push) begin
			data_q[1] <= mem_data;
			err_q[1]  <= mem_data_err;
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_tracker.sv ====
// bus pipeline tracking for the fetch frontend
// count of fetches in flight and of fetches still to be flushed after a jump
// liveness of arriving data and the fetch stall decision

`timescale 1ns/1ps
`default_nettype none

module bus_tracker (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  fetch_issue,
	input  wire  jump_now,
	input  wire  mem_data_vld,
	input  wire  queue_full,
	input  wire  queue_almost_full,
	output logic data_live,
	output logic fetch_stall
);

	import fetch_pkg::*;

	level_t pending_q;
	level_t flush_q;

	// words from fetches issued before a jump arrive while the flush count is nonzero
	assign data_live = mem_data_vld && (flush_q == 2'd0);

	// registered counts only, so bus ready never reaches the address phase
	// combinationally
	// an almost full queue can take one more word but not two
	assign fetch_stall = queue_full
		|| (queue_almost_full && (pending_q != 2'd0))
		|| (pending_q >= MAX_PENDING);

	// ------------------------------------------------------------
	// counters
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending_q <= 2'd0;
			flush_q   <= 2'd0;
		end else begin
			pending_q <= pending_q + level_t'(fetch_issue) - level_t'(mem_data_vld);
			// the fetch issued in the jump cycle belongs to the new stream
			if (jump_now) begin
				flush_q <= pending_q - level_t'(mem_data_vld);
			end else if ((flush_q != 2'd0) && mem_data_vld) begin
				flush_q <= flush_q - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
// fetch address phase control
// address phase FSM with reset holdoff and repeat of a stalled address
// fetch address register, jump acceptance and post-increment
// halfword validity of the word in the address phase and in the data phase

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
	parameter fetch_pkg::addr_t RESET_VECTOR = '0
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire fetch_pkg::addr_t  jump_target,
	input  wire                    jump_target_vld,
	output logic                   jump_target_rdy,
	output logic                   jump_now,
	output fetch_pkg::addr_t       mem_addr,
	output logic                   mem_addr_vld,
	input  wire                    mem_addr_rdy,
	input  wire                    fetch_stall,
	output logic                   fetch_issue,
	output fetch_pkg::hw_mask_t    data_hw_mask
);

	import fetch_pkg::*;

	fetch_state_t state_q;
	fetch_state_t state_d;
	addr_t        fetch_addr_q;
	addr_t        jump_word;
	hw_mask_t     aph_mask_q;
	hw_mask_t     data_mask_q;
	hw_mask_t     present_mask;
	logic         gap_q;
	logic         jump_sel;
	logic         transfer;

	// the bus only ever sees word-aligned addresses
	assign jump_word = {jump_target[31:2], 2'b00};

	// a held address must not change, so jumps wait until the hold resolves
	assign jump_target_rdy = (state_q != FS_HOLD);
	assign jump_now        = jump_target_vld && jump_target_rdy;

	// ------------------------------------------------------------
	// address phase request
	// ------------------------------------------------------------

	// the jump target goes straight out in the cycle it is requested
	always_comb begin
		mem_addr     = fetch_addr_q;
		mem_addr_vld = 1'b0;
		jump_sel     = 1'b0;
		case (state_q)
			FS_HOLDOFF: mem_addr_vld = 1'b0;
			FS_HOLD:    mem_addr_vld = 1'b1;
			default: begin
				// stall and the alignment gap block jumps as well as sequential fetches
				mem_addr_vld = !fetch_stall && !gap_q;
				if (jump_target_vld) begin
					mem_addr = jump_word;
					jump_sel = 1'b1;
				end
			end
		endcase
	end

	// a repeat of a held address is not a new fetch
	assign fetch_issue = mem_addr_vld && (state_q != FS_HOLD);
	assign transfer    = mem_addr_vld && mem_addr_rdy;

	// a word fetched for a target with bit 1 set starts at its upper halfword
	assign present_mask = jump_sel ? {1'b1, !jump_target[1]} : aph_mask_q;
	assign state_d      = (mem_addr_vld && !mem_addr_rdy) ? FS_HOLD : FS_RUN;
	assign data_hw_mask = data_mask_q;

	// ------------------------------------------------------------
	// fetch address and halfword masks
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q      <= FS_HOLDOFF;
			fetch_addr_q <= RESET_VECTOR;
			aph_mask_q   <= 2'b11;
			data_mask_q  <= 2'b11;
			gap_q        <= 1'b0;
		end else begin
			state_q <= state_d;
			// the data phase mask belongs to the misaligned word until that word is back,
			// and the bus returns it within two cycles, so the next transfer waits one
			gap_q <= transfer && !present_mask[0];
			if (jump_now && transfer) begin
				fetch_addr_q <= jump_word + WORD_BYTES;
			end else if (jump_now) begin
				fetch_addr_q <= jump_word;
			end else if (transfer) begin
				fetch_addr_q <= fetch_addr_q + WORD_BYTES;
			end
			// the mask moves to the data phase with its transfer
			if (transfer) begin
				data_mask_q <= present_mask;
				aph_mask_q  <= 2'b11;
			end else if (jump_now) begin
				aph_mask_q <= {1'b1, !jump_target[1]};
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
// shared definitions for the instruction fetch frontend
// vector types for addresses, bus words, halfwords and halfword masks
// fetch address phase state encoding
// bus constants for the fetch step and the outstanding-fetch limit

`default_nettype none

package fetch_pkg;

	// fetch and jump byte addresses
	typedef logic [31:0] addr_t;

	// one bus data word that is always fetched whole and word-aligned
	typedef logic [31:0] word_t;

	// one instruction halfword, the unit that decode consumes
	typedef logic [15:0] half_t;

	// one flag per halfword of a word with bit 0 for the lower halfword
	typedef logic [1:0] hw_mask_t;

	// small counts of halfwords in the instruction register or of fetches on the bus
	typedef logic [1:0] level_t;

	// address phase state
	// FS_HOLDOFF is the single idle cycle after reset
	// FS_RUN may present a fresh address, FS_HOLD repeats one the bus did not take
	typedef enum logic [1:0] {
		FS_HOLDOFF,
		FS_RUN,
		FS_HOLD
	} fetch_state_t;

	// byte step between consecutive fetches
	localparam addr_t WORD_BYTES = 32'd4;

	// the frontend never has more fetches in flight than this
	localparam level_t MAX_PENDING = 2'd2;

endpackage

`default_nettype wire
